// ==== source/vector_pkg.sv ====
`default_nettype none

package vector_pkg;

    localparam int VLEN  = 64;            // Width of one vector register in bits.
    localparam int VLENB = VLEN / 8;      // SEW is 8, so one element per byte.

    localparam logic [6:0] OPCODE_OPV   = 7'b1010111;
    localparam logic [2:0] FUNCT3_OPIVV = 3'b000;
    localparam logic [2:0] FUNCT3_OPIVI = 3'b011;

    localparam logic [5:0] F6_VADD   = 6'b000000;
    localparam logic [5:0] F6_VSUB   = 6'b000010;
    localparam logic [5:0] F6_VAND   = 6'b001001;
    localparam logic [5:0] F6_VOR    = 6'b001010;
    localparam logic [5:0] F6_VXOR   = 6'b001011;
    localparam logic [5:0] F6_VMERGE = 6'b010111;   // Also vmv when vm=1 and vs2=0.

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } opivv_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] simm5;                  // Signed immediate in the vs1 slot.
        logic [2:0] funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } opivi_t;

    typedef union packed {
        opivv_t vv;
        opivi_t vi;
    } vec_instr_u;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MOVE,
        OP_MERGE,
        OP_LOAD
    } vec_op_e;

    typedef struct packed {
        logic       valid;
        vec_instr_u instr;
    } instr_req_t;

    typedef struct packed {
        logic            valid;
        logic [4:0]      vd;
        logic [VLEN-1:0] data;
    } load_req_t;

    typedef struct packed {
        logic             valid;
        vec_op_e          op;
        logic [4:0]       vd;
        logic             vm;
        logic [4:0]       vs2;              // Source numbers for the execute bypass.
        logic [4:0]       vs1;
        logic             b_is_reg;         // The src_b operand came from vs1.
        logic [VLEN-1:0]  src_a;
        logic [VLEN-1:0]  src_b;
        logic [VLENB-1:0] mask;
    } issue_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       vd;
        logic [VLENB-1:0] enable;
        logic [VLEN-1:0]  data;
    } wb_t;

    // Replaces the bytes of a register value that an in-flight writeback is about to change.
    function automatic logic [VLEN-1:0] forward_bytes(
        input logic [4:0]      addr,
        input logic [VLEN-1:0] data,
        input wb_t             wb
    );
        logic [VLEN-1:0] merged;
        merged = data;
        for (int i = 0; i < VLENB; i++) begin
            if (wb.valid && wb.vd == addr && wb.enable[i]) begin
                merged[8*i +: 8] = wb.data[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

// ==== source/vector_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_issue (
    input  logic                        clk,
    input  logic                        reset_n,
    input  vector_pkg::instr_req_t      instr_req,
    input  vector_pkg::load_req_t       load_req,
    output logic [4:0]                  vs1_addr,
    output logic [4:0]                  vs2_addr,
    input  logic [vector_pkg::VLEN-1:0] vs1_data,
    input  logic [vector_pkg::VLEN-1:0] vs2_data,
    input  logic [vector_pkg::VLEN-1:0] v0_mask,
    input  vector_pkg::wb_t             wb,
    output vector_pkg::issue_t          issue
);

    vector_pkg::vec_instr_u      instr;
    logic                        is_vv;
    logic                        is_vi;
    logic                        dec_valid;
    vector_pkg::vec_op_e         dec_op;
    logic [7:0]                  imm_byte;
    logic [vector_pkg::VLEN-1:0] vs1_fwd;
    logic [vector_pkg::VLEN-1:0] vs2_fwd;
    logic [vector_pkg::VLEN-1:0] v0_fwd;
    vector_pkg::issue_t          issue_next;

    assign instr    = instr_req.instr;
    assign vs1_addr = instr.vv.vs1;
    assign vs2_addr = instr.vv.vs2;

    // The funct3 field picks which view of the word is meaningful.
    assign is_vv = (instr.vv.opcode == vector_pkg::OPCODE_OPV)
                && (instr.vv.funct3 == vector_pkg::FUNCT3_OPIVV);
    assign is_vi = (instr.vi.opcode == vector_pkg::OPCODE_OPV)
                && (instr.vi.funct3 == vector_pkg::FUNCT3_OPIVI);

    assign imm_byte = {{3{instr.vi.simm5[4]}}, instr.vi.simm5};   // Sign extension to SEW.

    // Bytes still sitting in the writeback register are newer than the bank.
    assign vs1_fwd = vector_pkg::forward_bytes(vs1_addr, vs1_data, wb);
    assign vs2_fwd = vector_pkg::forward_bytes(vs2_addr, vs2_data, wb);
    assign v0_fwd  = vector_pkg::forward_bytes(5'd0, v0_mask, wb);

    always_comb begin
        dec_valid = is_vv || is_vi;
        dec_op    = vector_pkg::OP_ADD;
        case (instr.vv.funct6)
            vector_pkg::F6_VADD: dec_op = vector_pkg::OP_ADD;
            vector_pkg::F6_VSUB: begin
                dec_op    = vector_pkg::OP_SUB;
                dec_valid = is_vv;                  // There is no vsub.vi.
            end
            vector_pkg::F6_VAND: dec_op = vector_pkg::OP_AND;
            vector_pkg::F6_VOR:  dec_op = vector_pkg::OP_OR;
            vector_pkg::F6_VXOR: dec_op = vector_pkg::OP_XOR;
            vector_pkg::F6_VMERGE: begin
                if (!instr.vv.vm) begin
                    dec_op = vector_pkg::OP_MERGE;
                end else if (instr.vv.vs2 == 5'd0) begin
                    dec_op = vector_pkg::OP_MOVE;
                end else begin
                    dec_valid = 1'b0;               // Reserved form of the funct6.
                end
            end
            default: dec_valid = 1'b0;
        endcase
    end

    always_comb begin
        issue_next.vs2   = vs2_addr;
        issue_next.vs1   = vs1_addr;
        issue_next.src_a = vs2_fwd;
        issue_next.mask  = v0_fwd[vector_pkg::VLENB-1:0];
        if (load_req.valid) begin
            issue_next.valid    = 1'b1;
            issue_next.op       = vector_pkg::OP_LOAD;
            issue_next.vd       = load_req.vd;
            issue_next.vm       = 1'b1;
            issue_next.b_is_reg = 1'b0;
            issue_next.src_b    = load_req.data;
        end else begin
            issue_next.valid    = instr_req.valid && dec_valid;
            issue_next.op       = dec_op;
            issue_next.vd       = instr.vv.vd;
            issue_next.vm       = instr.vv.vm;
            issue_next.b_is_reg = is_vv;
            issue_next.src_b    = is_vi ? {vector_pkg::VLENB{imm_byte}} : vs1_fwd;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue <= '0;
        end else begin
            issue <= issue_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/vector_regbank.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_regbank (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [4:0]                  vs1_addr,
    input  logic [4:0]                  vs2_addr,
    input  vector_pkg::wb_t             wb,
    output logic [vector_pkg::VLEN-1:0] vs1_data,
    output logic [vector_pkg::VLEN-1:0] vs2_data,
    output logic [vector_pkg::VLEN-1:0] v0_mask
);

    logic [31:0][vector_pkg::VLEN-1:0] regfile;

    assign vs1_data = regfile[vs1_addr];
    assign vs2_data = regfile[vs2_addr];
    assign v0_mask  = regfile[0];             // v0 always feeds the mask path.

    for (genvar j = 0; j < 32; j++) begin : gen_reg
        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                regfile[j] <= '0;
            end else if (wb.valid && wb.vd == 5'(j)) begin
                for (int i = 0; i < vector_pkg::VLENB; i++) begin
                    if (wb.enable[i]) begin
                        regfile[j][8*i +: 8] <= wb.data[8*i +: 8];   // Masked-off bytes keep their value.
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/vector_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_exec (
    input  logic               clk,
    input  logic               reset_n,
    input  vector_pkg::issue_t issue,
    output vector_pkg::wb_t    wb
);

    logic [vector_pkg::VLEN-1:0]  src_a;
    logic [vector_pkg::VLEN-1:0]  src_b;
    logic [vector_pkg::VLENB-1:0] mask;
    vector_pkg::wb_t              wb_next;

    // The previous result is still in wb while this record executes, so it is
    // bypassed here. The issue stage covers the result one step older.
    assign src_a = vector_pkg::forward_bytes(issue.vs2, issue.src_a, wb);
    assign src_b = issue.b_is_reg ? vector_pkg::forward_bytes(issue.vs1, issue.src_b, wb)
                                  : issue.src_b;
    assign mask  = (wb.valid && wb.vd == 5'd0 && wb.enable[0])
                 ? wb.data[vector_pkg::VLENB-1:0] : issue.mask;

    always_comb begin
        logic [7:0] a_byte;
        logic [7:0] b_byte;
        logic [7:0] r_byte;
        wb_next.valid = issue.valid;
        wb_next.vd    = issue.vd;
        for (int i = 0; i < vector_pkg::VLENB; i++) begin
            a_byte = src_a[8*i +: 8];
            b_byte = src_b[8*i +: 8];
            case (issue.op)
                vector_pkg::OP_ADD:   r_byte = a_byte + b_byte;   // Wraps at 8 bits.
                vector_pkg::OP_SUB:   r_byte = a_byte - b_byte;   // vs2 minus vs1.
                vector_pkg::OP_AND:   r_byte = a_byte & b_byte;
                vector_pkg::OP_OR:    r_byte = a_byte | b_byte;
                vector_pkg::OP_XOR:   r_byte = a_byte ^ b_byte;
                vector_pkg::OP_MERGE: r_byte = mask[i] ? b_byte : a_byte;
                default:              r_byte = b_byte;            // Move and load.
            endcase
            wb_next.data[8*i +: 8] = r_byte;
            case (issue.op)
                vector_pkg::OP_MERGE,
                vector_pkg::OP_MOVE,
                vector_pkg::OP_LOAD: wb_next.enable[i] = 1'b1;
                default:             wb_next.enable[i] = issue.vm || mask[i];
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb <= '0;
        end else begin
            wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/vector_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  vector_pkg::instr_req_t instr_req,
    input  vector_pkg::load_req_t  load_req,
    output vector_pkg::wb_t        wb
);

    logic [4:0]                  vs1_addr;
    logic [4:0]                  vs2_addr;
    logic [vector_pkg::VLEN-1:0] vs1_data;
    logic [vector_pkg::VLEN-1:0] vs2_data;
    logic [vector_pkg::VLEN-1:0] v0_mask;
    vector_pkg::issue_t          issue;

    vector_issue issue0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .instr_req (instr_req),
        .load_req  (load_req),
        .vs1_addr  (vs1_addr),
        .vs2_addr  (vs2_addr),
        .vs1_data  (vs1_data),
        .vs2_data  (vs2_data),
        .v0_mask   (v0_mask),
        .wb        (wb),
        .issue     (issue)
    );

    vector_regbank regbank0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .vs1_addr (vs1_addr),
        .vs2_addr (vs2_addr),
        .wb       (wb),
        .vs1_data (vs1_data),
        .vs2_data (vs2_data),
        .v0_mask  (v0_mask)
    );

    vector_exec exec0 (
        .clk     (clk),
        .reset_n (reset_n),
        .issue   (issue),
        .wb      (wb)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;                  // 100 ns period.

endmodule

`default_nettype wire

// ==== bench/vector_unit_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_unit_props (
    input logic                   clk,
    input logic                   reset_n,
    input vector_pkg::instr_req_t instr_req,
    input vector_pkg::load_req_t  load_req,
    input vector_pkg::wb_t        wb
);

    a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
        !(instr_req.valid && load_req.valid))
        else $error("instr_req and load_req were valid in the same cycle");

    // Nothing can have been issued yet in the first two cycles out of reset.
    a_quiet_first: assert property (@(posedge clk)
        (reset_n && !$past(reset_n)) |-> !wb.valid)
        else $error("wb.valid was high in the first cycle after reset");

    a_quiet_second: assert property (@(posedge clk)
        (reset_n && $past(reset_n) && !$past(reset_n, 2)) |-> !wb.valid)
        else $error("wb.valid was high in the second cycle after reset");

    a_wb_known: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown(wb.valid) && (!wb.valid || !$isunknown(wb.vd)))
        else $error("wb carries unknown control bits");

endmodule

bind vector_unit vector_unit_props props0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .instr_req (instr_req),
    .load_req  (load_req),
    .wb        (wb)
);

`default_nettype wire

// ==== bench/vector_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_unit_tb;

    logic                        clk;
    logic                        reset_n;
    vector_pkg::instr_req_t      instr_req;
    vector_pkg::load_req_t       load_req;
    vector_pkg::wb_t             wb;
    logic [vector_pkg::VLEN-1:0] ref_regs [0:31];   // Sequential model of the register bank.
    vector_pkg::wb_t             pending [$];       // Expected wb, two steps behind.

    tb_clock clock0 (.clk(clk));

    vector_unit dut0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .instr_req (instr_req),
        .load_req  (load_req),
        .wb        (wb)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic compare_wb(input vector_pkg::wb_t actual, input vector_pkg::wb_t expected);
        if (actual.valid === 1'b1 && !expected.valid) begin
            fail_run($sformatf("A writeback to v%0d appeared where none was expected", actual.vd));
        end else if (actual.valid !== expected.valid) begin
            fail_run($sformatf("FAIL wb.valid got %h expected %h", actual.valid,
                               expected.valid));
        end else if (expected.valid && actual.vd !== expected.vd) begin
            fail_run($sformatf("FAIL wb.vd got %h expected %h", actual.vd, expected.vd));
        end else if (expected.valid && actual.enable !== expected.enable) begin
            fail_run($sformatf("FAIL wb.enable got %h expected %h", actual.enable,
                               expected.enable));
        end else if (expected.valid && actual.data !== expected.data) begin
            fail_run($sformatf("FAIL wb.data got %h expected %h", actual.data, expected.data));
        end
    endtask

    function automatic logic [31:0] encode(input logic [5:0] f6, input logic vm,
                                           input logic [4:0] vs2, input logic [4:0] vs1,
                                           input logic [2:0] f3, input logic [4:0] vd);
        return {f6, vm, vs2, vs1, f3, vd, vector_pkg::OPCODE_OPV};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(31, 1));      // v0 is only written on purpose.
    endfunction

    function automatic logic [vector_pkg::VLEN-1:0] rand_data();
        return {$urandom(), $urandom()};
    endfunction

    function automatic logic [4:0] rand_imm();
        return 5'($urandom());
    endfunction

    // Works out the writeback of one instruction word and updates the model.
    task automatic predict_instr(input logic [31:0] word, output vector_pkg::wb_t exp);
        logic [4:0]                  vs2;
        logic [4:0]                  vs1;
        logic [4:0]                  vd;
        logic [2:0]                  f3;
        logic [5:0]                  f6;
        logic                        vm;
        logic                        ok;
        logic [7:0]                  imm;
        logic [7:0]                  m;
        logic [7:0]                  r;
        logic [vector_pkg::VLEN-1:0] a;
        logic [vector_pkg::VLEN-1:0] b;
        f6  = word[31:26];
        vm  = word[25];
        vs2 = word[24:20];
        vs1 = word[19:15];
        f3  = word[14:12];
        vd  = word[11:7];
        imm = {{3{vs1[4]}}, vs1};
        a   = ref_regs[vs2];
        b   = (f3 == vector_pkg::FUNCT3_OPIVI) ? {8{imm}} : ref_regs[vs1];
        m   = ref_regs[0][7:0];
        ok  = (word[6:0] == vector_pkg::OPCODE_OPV)
           && (f3 == vector_pkg::FUNCT3_OPIVV || f3 == vector_pkg::FUNCT3_OPIVI);
        case (f6)
            vector_pkg::F6_VADD, vector_pkg::F6_VAND,
            vector_pkg::F6_VOR, vector_pkg::F6_VXOR: ;
            vector_pkg::F6_VSUB:   ok = ok && (f3 == vector_pkg::FUNCT3_OPIVV);
            vector_pkg::F6_VMERGE: ok = ok && (!vm || vs2 == 5'd0);
            default:               ok = 1'b0;
        endcase
        exp = '0;
        if (ok) begin
            exp.valid = 1'b1;
            exp.vd    = vd;
            for (int i = 0; i < vector_pkg::VLENB; i++) begin
                case (f6)
                    vector_pkg::F6_VADD: r = a[8*i +: 8] + b[8*i +: 8];
                    vector_pkg::F6_VSUB: r = a[8*i +: 8] - b[8*i +: 8];
                    vector_pkg::F6_VAND: r = a[8*i +: 8] & b[8*i +: 8];
                    vector_pkg::F6_VOR:  r = a[8*i +: 8] | b[8*i +: 8];
                    vector_pkg::F6_VXOR: r = a[8*i +: 8] ^ b[8*i +: 8];
                    default:             r = (vm || m[i]) ? b[8*i +: 8] : a[8*i +: 8];
                endcase
                exp.data[8*i +: 8] = r;
                exp.enable[i] = vm || m[i] || (f6 == vector_pkg::F6_VMERGE);
            end
            for (int i = 0; i < vector_pkg::VLENB; i++) begin
                if (exp.enable[i]) begin
                    ref_regs[vd][8*i +: 8] = exp.data[8*i +: 8];
                end
            end
        end
    endtask

    // One falling edge: check the result of the request two steps back, then drive.
    task automatic clock_step(input vector_pkg::instr_req_t ir, input vector_pkg::load_req_t lr,
                              input vector_pkg::wb_t exp);
        @(negedge clk);
        compare_wb(wb, pending.pop_front());
        instr_req = ir;
        load_req  = lr;
        pending.push_back(exp);
    endtask

    task automatic send_instr(input logic [31:0] word);
        vector_pkg::instr_req_t ir;
        vector_pkg::load_req_t  lr;
        vector_pkg::wb_t        exp;
        ir.valid = 1'b1;
        ir.instr = vector_pkg::vec_instr_u'(word);
        lr       = '0;
        predict_instr(word, exp);
        clock_step(ir, lr, exp);
    endtask

    task automatic send_load(input logic [4:0] vd, input logic [vector_pkg::VLEN-1:0] data);
        vector_pkg::instr_req_t ir;
        vector_pkg::load_req_t  lr;
        vector_pkg::wb_t        exp;
        ir           = '0;
        lr.valid     = 1'b1;
        lr.vd        = vd;
        lr.data      = data;
        exp.valid    = 1'b1;
        exp.vd       = vd;
        exp.enable   = '1;
        exp.data     = data;
        ref_regs[vd] = data;
        clock_step(ir, lr, exp);
    endtask

    task automatic drain_pipeline();
        vector_pkg::instr_req_t ir;
        vector_pkg::load_req_t  lr;
        vector_pkg::wb_t        exp;
        ir  = '0;
        lr  = '0;
        exp = '0;
        repeat (2) clock_step(ir, lr, exp);
    endtask

    task automatic test_load_move();
        logic [4:0] ra;
        ra = rand_reg();
        send_load(ra, rand_data());
        send_instr(encode(vector_pkg::F6_VMERGE, 1'b1, 5'd0, ra, vector_pkg::FUNCT3_OPIVV,
                          rand_reg()));
        send_instr(encode(vector_pkg::F6_VMERGE, 1'b1, 5'd0, rand_imm(),
                          vector_pkg::FUNCT3_OPIVI, rand_reg()));
        drain_pipeline();
    endtask

    task automatic test_arith_logic();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rd;
        repeat (4) begin
            ra = rand_reg();
            rb = rand_reg();
            rd = rand_reg();
            send_load(ra, rand_data());
            send_load(rb, rand_data());
            send_instr(encode(vector_pkg::F6_VADD, 1'b1, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VSUB, 1'b1, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VAND, 1'b1, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VOR, 1'b1, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VXOR, 1'b1, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VADD, 1'b1, ra, rand_imm(),
                              vector_pkg::FUNCT3_OPIVI, rd));
            send_instr(encode(vector_pkg::F6_VAND, 1'b1, rb, rand_imm(),
                              vector_pkg::FUNCT3_OPIVI, rd));
            send_instr(encode(vector_pkg::F6_VOR, 1'b1, ra, rand_imm(),
                              vector_pkg::FUNCT3_OPIVI, rd));
            send_instr(encode(vector_pkg::F6_VXOR, 1'b1, rb, rand_imm(),
                              vector_pkg::FUNCT3_OPIVI, rd));
        end
        drain_pipeline();
    endtask

    task automatic test_masking();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rd;
        repeat (3) begin
            ra = rand_reg();
            rb = rand_reg();
            rd = rand_reg();
            send_load(5'd0, rand_data());
            send_load(ra, rand_data());
            send_load(rb, rand_data());
            send_load(rd, rand_data());
            send_instr(encode(vector_pkg::F6_VADD, 1'b0, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VSUB, 1'b0, rb, ra, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VAND, 1'b0, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VOR, 1'b0, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VXOR, 1'b0, ra, rb, vector_pkg::FUNCT3_OPIVV, rd));
            send_instr(encode(vector_pkg::F6_VXOR, 1'b0, rb, rand_imm(),
                              vector_pkg::FUNCT3_OPIVI, rd));
            send_instr(encode(vector_pkg::F6_VMERGE, 1'b1, 5'd0, rd, vector_pkg::FUNCT3_OPIVV,
                              rand_reg()));   // Shows the bytes left alone.
        end
        drain_pipeline();
    endtask

    task automatic test_merge();
        logic [4:0] ra;
        logic [4:0] rb;
        repeat (3) begin
            ra = rand_reg();
            rb = rand_reg();
            send_load(5'd0, rand_data());
            send_load(ra, rand_data());
            send_load(rb, rand_data());
            send_instr(encode(vector_pkg::F6_VMERGE, 1'b0, ra, rb, vector_pkg::FUNCT3_OPIVV,
                              rand_reg()));
            send_instr(encode(vector_pkg::F6_VMERGE, 1'b0, rb, rand_imm(),
                              vector_pkg::FUNCT3_OPIVI, rand_reg()));
        end
        drain_pipeline();
    endtask

    task automatic test_forwarding();
        logic [4:0] ra;
        logic [4:0] rb;
        logic [4:0] rc;
        repeat (2) begin
            ra = rand_reg();
            rb = rand_reg();
            rc = rand_reg();
            send_load(ra, rand_data());
            send_load(rb, rand_data());
            send_instr(encode(vector_pkg::F6_VADD, 1'b1, ra, rb, vector_pkg::FUNCT3_OPIVV, rc));
            send_instr(encode(vector_pkg::F6_VXOR, 1'b1, rc, rb, vector_pkg::FUNCT3_OPIVV, ra));
            send_instr(encode(vector_pkg::F6_VSUB, 1'b1, ra, rc, vector_pkg::FUNCT3_OPIVV, rb));
            send_instr(encode(vector_pkg::F6_VOR, 1'b1, rb, rand_imm(),
                              vector_pkg::FUNCT3_OPIVI, rc));
            send_load(5'd0, rand_data());
            send_instr(encode(vector_pkg::F6_VAND, 1'b1, rc, rb, vector_pkg::FUNCT3_OPIVV,
                              5'd0));          // New mask written just before use.
            send_instr(encode(vector_pkg::F6_VADD, 1'b0, ra, rb, vector_pkg::FUNCT3_OPIVV, rc));
            send_instr(encode(vector_pkg::F6_VADD, 1'b0, rc, ra, vector_pkg::FUNCT3_OPIVV,
                              5'd0));          // Partial write to v0 under its own mask.
            send_instr(encode(vector_pkg::F6_VMERGE, 1'b0, rb, rc, vector_pkg::FUNCT3_OPIVV,
                              ra));
            send_instr(encode(vector_pkg::F6_VMERGE, 1'b1, 5'd0, ra, vector_pkg::FUNCT3_OPIVV,
                              rb));
        end
        drain_pipeline();
    endtask

    task automatic test_ignored();
        logic [4:0]  ra;
        logic [31:0] word;
        ra = rand_reg();
        send_load(ra, rand_data());
        word       = encode(vector_pkg::F6_VADD, 1'b1, ra, ra, vector_pkg::FUNCT3_OPIVV, ra);
        word[6:0]  = 7'b0110011;               // Integer OP opcode.
        send_instr(word);
        send_instr(encode(vector_pkg::F6_VADD, 1'b1, ra, ra, 3'b100, ra));
        send_instr(encode(vector_pkg::F6_VSUB, 1'b1, ra, rand_imm(),
                          vector_pkg::FUNCT3_OPIVI, ra));
        send_instr(encode(vector_pkg::F6_VMERGE, 1'b1, ra, ra, vector_pkg::FUNCT3_OPIVV, ra));
        send_instr(encode(6'b000011, 1'b1, ra, ra, vector_pkg::FUNCT3_OPIVV, ra));
        send_instr(encode(vector_pkg::F6_VMERGE, 1'b1, 5'd0, ra, vector_pkg::FUNCT3_OPIVV,
                          rand_reg()));
        drain_pipeline();
    endtask

    initial begin
        void'($urandom(63825));
        reset_n     = 1'b0;
        instr_req   = '0;
        load_req    = '0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        repeat (2) pending.push_back('0);     // The pipeline starts empty.
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        test_load_move();
        test_arith_logic();
        test_masking();
        test_merge();
        test_forwarding();
        test_ignored();
        $display("Everything OK");
        $finish;
    end

    // Steps per test, then a margin of 20 cycles for reset and slack.
    initial begin
        int unsigned limit_cycles;
        limit_cycles = 5 + 46 + 35 + 17 + 26 + 9 + 20;
        #(limit_cycles * 100);
        fail_run("The watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

// ==== vector_unit.f ====
source/vector_pkg.sv
source/vector_issue.sv
source/vector_regbank.sv
source/vector_exec.sv
source/vector_unit.sv
bench/tb_clock.sv
bench/vector_unit_props.sv
bench/vector_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module vector_unit_tb \
    -f vector_unit.f \
    --Mdir obj_dir -o vector_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/vector_unit_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Everything OK"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
